/* tb.f */
verilog/lanes_cfg_pkg.sv
verilog/lanes_packet_pkg.sv
verilog/response_router.sv
verilog/lane_engine.sv
verilog/request_arbiter.sv
verilog/bundle_result.sv
verilog/bundle_lanes.sv
tests/bundle_lanes_chk.sv
tests/bundle_lanes_tb.sv

/* Makefile */
# Verilator build and run of the lane bundle testbench

TOP := bundle_lanes_tb

.PHONY: simulate clean

simulate:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f tb.f -Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

/* tests/bundle_lanes_tb.sv */
/*
 * Lane bundle testbench
 * Drives descriptors, models a memory with random gaps and back-pressure,
 * and compares each run's sum with a reference model
 */

`timescale 1ns/1ps

module bundle_lanes_tb
    import lanes_cfg_pkg::*;
    import lanes_packet_pkg::*;
();

    logic        ap_clk;
    logic        areset_lanes;
    descriptor_t descriptor_in;
    mem_packet_t response_in;
    mem_packet_t request_out;
    logic        mem_ready;
    logic        done_out;
    word_t       result_sum;

    // Shared by the stimulus and the memory model
    int          seed;
    bit          ready_random;
    word_t       run_base;
    int          run_count;
    int          taken_count;
    bit          seen [1024];
    mem_packet_t pending_q [$];

    bundle_lanes u_dut (
        .ap_clk        (ap_clk),
        .areset_lanes  (areset_lanes),
        .descriptor_in (descriptor_in),
        .response_in   (response_in),
        .request_out   (request_out),
        .mem_ready     (mem_ready),
        .done_out      (done_out),
        .result_sum    (result_sum)
    );

    initial begin
        ap_clk = 1'b0;
        forever #4 ap_clk = ~ap_clk;
    end

    // ----------------------------------------------------------------------
    // Reference model and checking
    // ----------------------------------------------------------------------
    function automatic word_t memory_word(input word_t address);
        return address * 32'd3 + 32'd1;
    endfunction

    // Lane i reads base + 4 * (i + k * lanes) for each k below count
    function automatic word_t expected_sum(input word_t base, input int count);
        word_t total;
        word_t address;
        total = '0;
        for (int k = 0; k < count; k++) begin
            for (int lane = 0; lane < num_lanes; lane++) begin
                address = base + word_t'(word_bytes * (lane + k * num_lanes));
                total   = total + memory_word(address);
            end
        end
        return total;
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("tests failed");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("ERR %0d ns: %s is 0x%08h, expected 0x%08h",
                                $time, what, got, exp));
        end
    endtask

    // Every address once, inside the run, on the lane that owns it
    task automatic check_request(input mem_packet_t req);
        word_t offset;
        int    idx;
        offset = req.word.address - run_base;
        check_value("request address alignment", 32'(offset[1:0]), 32'd0);
        idx = int'(offset >> 2);
        check_value("request address inside the run", 32'(idx < num_lanes * run_count), 32'd1);
        check_value("repeated request address", 32'(seen[idx]), 32'd0);
        seen[idx] = 1'b1;
        check_value("request lane id", 32'(req.id), 32'(idx % num_lanes));
    endtask

    task automatic wait_for_done(input logic level, input int limit, input string event_name);
        int cycles;
        cycles = 0;
        while (done_out !== level) begin
            if (cycles == limit) begin
                abort_run({"timeout: ", event_name, " never came"});
            end
            @(negedge ap_clk);
            cycles++;
        end
    endtask

    task automatic pulse_descriptor(input word_t base, input logic [count_bits-1:0] count);
        @(negedge ap_clk);
        descriptor_in.valid = 1'b1;
        descriptor_in.base  = base;
        descriptor_in.count = count;
        @(negedge ap_clk);
        descriptor_in.valid = 1'b0;
    endtask

    // One full run with an optional second descriptor while busy
    task automatic run_descriptor(input word_t base, input logic [count_bits-1:0] count,
                                  input bit send_extra);
        run_base    = base;
        run_count   = int'(count);
        taken_count = 0;
        foreach (seen[i]) begin
            seen[i] = 1'b0;
        end
        pulse_descriptor(base, count);
        wait_for_done(1'b0, 8, "done_out falling after a descriptor");
        if (send_extra) begin
            pulse_descriptor(base + 32'h0010_0000, count + 8'd3);
        end
        wait_for_done(1'b1, 20000, "done_out rising at the end of a run");
        check_value("taken requests", 32'(taken_count), 32'(num_lanes * run_count));
        check_value("result_sum", result_sum, expected_sum(base, run_count));
    endtask

    // ----------------------------------------------------------------------
    // In-order memory responses after a random gap
    // ----------------------------------------------------------------------
    initial begin : memory_model
        mem_packet_t req;
        mem_packet_t rsp;
        int          gap;
        gap = 0;
        forever begin
            @(negedge ap_clk);
            rsp = '0;
            if (pending_q.size() > 0) begin
                if (gap == 0) begin
                    req             = pending_q.pop_front();
                    rsp.valid       = 1'b1;
                    rsp.id          = req.id;
                    rsp.word.data   = memory_word(req.word.address);
                    gap             = $random(seed) & 3;
                end else begin
                    gap--;
                end
            end
            response_in = rsp;

            // Ready level seen at the coming rising edge
            if (ready_random) begin
                mem_ready = (($random(seed) & 3) != 0);
            end else begin
                mem_ready = 1'b1;
            end

            if (!areset_lanes && request_out.valid && mem_ready) begin
                check_request(request_out);
                pending_q.push_back(request_out);
                taken_count++;
            end
        end
    end

    // ----------------------------------------------------------------------
    // Test sequence
    // ----------------------------------------------------------------------
    initial begin
        word_t                 base;
        logic [count_bits-1:0] count;

        seed          = 86;
        ready_random  = 1'b0;
        descriptor_in = '0;
        response_in   = '0;
        mem_ready     = 1'b1;
        areset_lanes  = 1'b1;
        repeat (2) @(negedge ap_clk);
        areset_lanes = 1'b0;
        @(negedge ap_clk);

        // Idle state after reset
        check_value("done_out after reset", 32'(done_out), 32'd1);
        check_value("request valid after reset", 32'(request_out.valid), 32'd0);
        check_value("result_sum after reset", result_sum, 32'd0);

        // Single word per lane
        run_descriptor(32'h0000_1000, 8'd1, 1'b0);

        // Longer run under back-pressure
        ready_random = 1'b1;
        run_descriptor(32'h0002_0040, 8'd24, 1'b0);

        // Descriptor while busy must be dropped
        run_descriptor(32'h0000_8000, 8'd9, 1'b1);

        // Back-to-back random runs
        for (int r = 0; r < 6; r++) begin
            base  = $random(seed);
            count = count_bits'(1 + ($random(seed) & 31));
            run_descriptor(base, count, 1'b0);
        end

        $display("all tests passed");
        $finish;
    end

endmodule : bundle_lanes_tb

/* tests/bundle_lanes_chk.sv */
/*
 * Lane bundle port checker
 * Concurrent assertions on the request port and the done level
 */

`timescale 1ns/1ps

module bundle_lanes_chk
    import lanes_cfg_pkg::*;
    import lanes_packet_pkg::*;
(
    input logic        ap_clk,
    input logic        areset_lanes,
    input mem_packet_t request_out,
    input logic        mem_ready,
    input logic        done_out
);

    // Stalled request holds its contents
    a_request_held: assert property (@(posedge ap_clk) disable iff (areset_lanes)
        (request_out.valid && !mem_ready) |=> $stable(request_out))
        else $error("request_out changed while mem_ready was low");

    // Valid request names a known, existing lane
    a_lane_id_range: assert property (@(posedge ap_clk) disable iff (areset_lanes)
        request_out.valid |-> (!$isunknown(request_out.id)
                               && (int'(request_out.id) < num_lanes)))
        else $error("request_out carries an unknown lane id or one beyond the last lane");

    // Idle bundle reports done right after reset
    a_done_after_reset: assert property (@(posedge ap_clk)
        areset_lanes |=> done_out)
        else $error("done_out was low in the cycle after reset");

endmodule : bundle_lanes_chk

bind bundle_lanes bundle_lanes_chk u_chk (
    .ap_clk       (ap_clk),
    .areset_lanes (areset_lanes),
    .request_out  (request_out),
    .mem_ready    (mem_ready),
    .done_out     (done_out)
);

/* verilog/bundle_lanes.sv */
/*
 * Lane bundle top level
 * Broadcasts the descriptor to all lanes, shares one memory port
 * between them and reports a combined done level and sum
 */

`timescale 1ns/1ps

module bundle_lanes
    import lanes_cfg_pkg::*;
    import lanes_packet_pkg::*;
(
    input  logic        ap_clk,
    input  logic        areset_lanes,
    input  descriptor_t descriptor_in,
    input  mem_packet_t response_in,
    output mem_packet_t request_out,
    input  logic        mem_ready,
    output logic        done_out,
    output word_t       result_sum
);

    descriptor_t          lane_descriptor;
    logic [num_lanes-1:0] lane_resp_valid;
    word_t                lane_resp_data;
    lane_req_t            lane_req [num_lanes];
    logic [num_lanes-1:0] grant;
    logic [num_lanes-1:0] lane_done;
    word_t                lane_sum [num_lanes];

    // Descriptors enter only while the whole bundle is idle
    assign lane_descriptor.valid = descriptor_in.valid && done_out;
    assign lane_descriptor.base  = descriptor_in.base;
    assign lane_descriptor.count = descriptor_in.count;

    // ----------------------------------------------------------------------
    // Memory response side
    // ----------------------------------------------------------------------
    response_router u_router (
        .ap_clk          (ap_clk),
        .areset_lanes    (areset_lanes),
        .response_in     (response_in),
        .lane_resp_valid (lane_resp_valid),
        .lane_resp_data  (lane_resp_data)
    );

    // ----------------------------------------------------------------------
    // Lanes
    // ----------------------------------------------------------------------
    for (genvar i = 0; i < num_lanes; i++) begin : gen_lanes
        lane_engine u_lane (
            .ap_clk        (ap_clk),
            .areset_lanes  (areset_lanes),
            .lane_index    (lane_id_t'(i)),
            .descriptor_in (lane_descriptor),
            .resp_valid    (lane_resp_valid[i]),
            .resp_data     (lane_resp_data),
            .grant         (grant[i]),
            .lane_req      (lane_req[i]),
            .lane_done     (lane_done[i]),
            .lane_sum      (lane_sum[i])
        );
    end

    // ----------------------------------------------------------------------
    // Memory request side and result
    // ----------------------------------------------------------------------
    request_arbiter u_arbiter (
        .ap_clk       (ap_clk),
        .areset_lanes (areset_lanes),
        .lane_req     (lane_req),
        .mem_ready    (mem_ready),
        .grant        (grant),
        .request_out  (request_out)
    );

    bundle_result u_result (
        .ap_clk       (ap_clk),
        .areset_lanes (areset_lanes),
        .lane_done    (lane_done),
        .lane_sum     (lane_sum),
        .done_out     (done_out),
        .result_sum   (result_sum)
    );

endmodule : bundle_lanes

/* verilog/bundle_result.sv */
/*
 * Bundle result
 * Merges the lane done levels into one done level and adds
 * the lane sums into the bundle sum
 */

`timescale 1ns/1ps

module bundle_result
    import lanes_cfg_pkg::*;
    import lanes_packet_pkg::*;
(
    input  logic                 ap_clk,
    input  logic                 areset_lanes,
    input  logic [num_lanes-1:0] lane_done,
    input  word_t                lane_sum [num_lanes],
    output logic                 done_out,
    output word_t                result_sum
);

    word_t sum_total;

    // Wrapping add over all lanes
    always_comb begin
        sum_total = '0;
        for (int i = 0; i < num_lanes; i++) begin
            sum_total = sum_total + lane_sum[i];
        end
    end

    // ----------------------------------------------------------------------
    // Output registers
    // ----------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_lanes) begin
            // Idle bundle reports done
            done_out   <= 1'b1;
            result_sum <= '0;
        end else begin
            done_out   <= &lane_done;
            result_sum <= sum_total;
        end
    end

endmodule : bundle_result

/* verilog/request_arbiter.sv */
/*
 * Request arbiter
 * Round-robin selection among pending lane requests onto the single
 * registered memory request port, held while memory is not ready
 */

`timescale 1ns/1ps

module request_arbiter
    import lanes_cfg_pkg::*;
    import lanes_packet_pkg::*;
(
    input  logic                 ap_clk,
    input  logic                 areset_lanes,
    input  lane_req_t            lane_req [num_lanes],
    input  logic                 mem_ready,
    output logic [num_lanes-1:0] grant,
    output mem_packet_t          request_out
);

    lane_id_t last_winner;
    lane_id_t winner;
    logic     any_grant;
    logic     load;

    // Output register is free or emptied this cycle
    assign load = !request_out.valid || mem_ready;

    // ----------------------------------------------------------------------
    // Round-robin search, starting after the last winner
    // ----------------------------------------------------------------------
    always_comb begin
        lane_id_t cand;

        winner    = last_winner;
        any_grant = 1'b0;
        for (int off = 1; off <= num_lanes; off++) begin
            cand = lane_id_t'((int'(last_winner) + off) % num_lanes);
            if (load && !any_grant && lane_req[cand].pending) begin
                winner    = cand;
                any_grant = 1'b1;
            end
        end

        grant = '0;
        if (any_grant) begin
            grant[winner] = 1'b1;
        end
    end

    // ----------------------------------------------------------------------
    // Request output register
    // ----------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_lanes) begin
            request_out.valid <= 1'b0;
            // Lane 0 has first turn
            last_winner       <= lane_id_t'(num_lanes - 1);
        end else if (load) begin
            request_out.valid <= any_grant;
            if (any_grant) begin
                last_winner              <= winner;
                request_out.id           <= winner;
                request_out.word.address <= lane_req[winner].address;
            end
        end
    end

endmodule : request_arbiter

/* verilog/lane_engine.sv */
/*
 * Lane engine
 * Fetches a strided run of words for one lane and sums the returned data.
 * Requests are offered one at a time and several may be in flight
 */

`timescale 1ns/1ps

module lane_engine
    import lanes_cfg_pkg::*;
    import lanes_packet_pkg::*;
(
    input  logic        ap_clk,
    input  logic        areset_lanes,
    input  lane_id_t    lane_index,
    input  descriptor_t descriptor_in,
    input  logic        resp_valid,
    input  word_t       resp_data,
    input  logic        grant,
    output lane_req_t   lane_req,
    output logic        lane_done,
    output word_t       lane_sum
);

    // Lanes interleave word by word across the bundle
    localparam word_t stride = word_t'(word_bytes * num_lanes);

    logic                  busy;
    logic [count_bits-1:0] desc_count;
    logic [count_bits-1:0] issued;
    logic [count_bits-1:0] received;
    logic [count_bits-1:0] issued_next;
    logic                  taken;
    word_t                 first_address;

    assign first_address = descriptor_in.base + (word_t'(lane_index) * word_bytes);
    assign taken         = grant && lane_req.pending;
    assign issued_next   = issued + 1'b1;

    // ----------------------------------------------------------------------
    // Control and request state
    // ----------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_lanes) begin
            busy             <= 1'b0;
            issued           <= '0;
            received         <= '0;
            lane_req.pending <= 1'b0;
            lane_sum         <= '0;
        end else if (!busy) begin
            if (descriptor_in.valid) begin
                busy             <= 1'b1;
                issued           <= '0;
                received         <= '0;
                lane_req.pending <= 1'b0;
                lane_req.address <= first_address;
                desc_count       <= descriptor_in.count;
                lane_sum         <= '0;
            end
        end else begin
            // Request side, stalls while not granted
            if (taken) begin
                lane_req.address <= lane_req.address + stride;
                issued           <= issued_next;
                lane_req.pending <= (issued_next < desc_count);
            end else if (!lane_req.pending && (issued < desc_count)) begin
                lane_req.pending <= 1'b1;
            end

            // Response side
            if (resp_valid) begin
                lane_sum <= lane_sum + resp_data;
                received <= received + 1'b1;
            end

            // All issued and all returned
            if ((issued == desc_count) && (received == desc_count)) begin
                busy <= 1'b0;
            end
        end
    end

    assign lane_done = !busy;

endmodule : lane_engine

/* verilog/response_router.sv */
/*
 * Response router
 * Registers memory responses and steers each one to the lane
 * named by its lane id, as a one-hot strobe with a shared data word
 */

`timescale 1ns/1ps

module response_router
    import lanes_cfg_pkg::*;
    import lanes_packet_pkg::*;
(
    input  logic                 ap_clk,
    input  logic                 areset_lanes,
    input  mem_packet_t          response_in,
    output logic [num_lanes-1:0] lane_resp_valid,
    output word_t                lane_resp_data
);

    mem_packet_t response_reg;

    // ----------------------------------------------------------------------
    // Input register
    // ----------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_lanes) begin
            response_reg.valid <= 1'b0;
        end else begin
            response_reg.valid <= response_in.valid;
        end
    end

    always_ff @(posedge ap_clk) begin
        response_reg.id   <= response_in.id;
        response_reg.word <= response_in.word;
    end

    // ----------------------------------------------------------------------
    // Lane id decode
    // ----------------------------------------------------------------------
    always_comb begin
        lane_resp_valid = '0;
        for (int i = 0; i < num_lanes; i++) begin
            if (response_reg.valid && (response_reg.id == lane_id_t'(i))) begin
                lane_resp_valid[i] = 1'b1;
            end
        end
    end

    // Data word goes to every lane, only the strobed one takes it
    assign lane_resp_data = response_reg.word.data;

endmodule : response_router

/* verilog/lanes_packet_pkg.sv */
/*
 * Lane bundle packet types
 * Memory packet, kernel descriptor and per-lane request formats
 * carried between the router, the lanes, the arbiter and the result block
 */

package lanes_packet_pkg;

    import lanes_cfg_pkg::*;

    // ----------------------------------------------------------------------
    // Basic words
    // ----------------------------------------------------------------------
    typedef logic [lane_id_bits-1:0] lane_id_t;
    typedef logic [word_bits-1:0]    word_t;

    // Address on the request side, data on the response side
    typedef union packed {
        word_t address;
        word_t data;
    } mem_word_u;

    // ----------------------------------------------------------------------
    // Memory packet
    // ----------------------------------------------------------------------
    typedef struct packed {
        logic      valid;
        lane_id_t  id;
        mem_word_u word;
    } mem_packet_t;

    // ----------------------------------------------------------------------
    // Kernel descriptor, broadcast to all lanes
    // ----------------------------------------------------------------------
    typedef struct packed {
        logic                  valid;
        word_t                 base;
        // Words per lane
        logic [count_bits-1:0] count;
    } descriptor_t;

    // Current request offered by one lane
    typedef struct packed {
        logic  pending;
        word_t address;
    } lane_req_t;

endpackage : lanes_packet_pkg

/* verilog/lanes_cfg_pkg.sv */
/*
 * Lane bundle configuration
 * Geometry and sizing constants shared by every block of the bundle
 */

package lanes_cfg_pkg;

    // ----------------------------------------------------------------------
    // Bundle geometry
    // ----------------------------------------------------------------------
    localparam int num_lanes    = 4;
    localparam int lane_id_bits = 2;

    // ----------------------------------------------------------------------
    // Memory word and descriptor sizing
    // ----------------------------------------------------------------------
    localparam int word_bits  = 32;
    // Byte distance between two consecutive words
    localparam int word_bytes = 4;
    // Words fetched per lane, per descriptor
    localparam int count_bits = 8;

endpackage : lanes_cfg_pkg
